// File: ga_consts.svh
`ifndef GA_CONSTS_SVH
`define GA_CONSTS_SVH

// problem size
`define NUM_CITIES      8
`define POP_SIZE        16

// routes carried into the next generation untouched
`define ELITE_SIZE      2

// swap happens when the 8-bit chance field is below this
`define MUT_THRESHOLD   64

// random source start value and feedback taps
`define LFSR_SEED       10'h00A
`define LFSR_TAPS       10'h0B8

`endif

// File: ga_pkg.sv
`default_nettype none

`include "ga_consts.svh"

package ga_pkg;

    typedef logic [$clog2(`NUM_CITIES)-1:0] cityIdx_t;  // city number or position in a route
    typedef logic [$clog2(`POP_SIZE)-1:0]   routeIdx_t; // route slot or rank
    typedef logic [7:0]                     coord_t;    // x or y coordinate
    typedef logic [11:0]                    dist_t;     // 8 edges of up to 510 each
    typedef logic [7:0]                     genCount_t;

    // generation sequencer
    typedef enum logic [2:0] {
        IDLE,
        EVAL,
        RANK,
        BUILD,
        SWAP,
        DONE
    } gaState_t;

endpackage

`default_nettype wire

// File: ga_if.sv
`default_nettype none

// child bank write path plus parent read path into the population memory
interface popWritePort import ga_pkg::*; ();

    routeIdx_t rdRoute;  // parent route in the current bank
    cityIdx_t  rdPos;
    cityIdx_t  rdCity;   // one cycle after rdRoute/rdPos
    routeIdx_t wrRoute;  // child slot in the other bank
    cityIdx_t  wrPos;
    cityIdx_t  wrCity;
    logic      wrEn;

    modport builder (
        output rdRoute,
        output rdPos,
        input  rdCity,
        output wrRoute,
        output wrPos,
        output wrCity,
        output wrEn
    );

    modport store (
        input  rdRoute,
        input  rdPos,
        output rdCity,
        input  wrRoute,
        input  wrPos,
        input  wrCity,
        input  wrEn
    );

endinterface

`default_nettype wire

// File: gaLfsr.sv
`default_nettype none

`include "ga_consts.svh"

module gaLfsr (
    input  logic       CLK,
    input  logic       RESET,
    output logic [9:0] randBits
);

    localparam logic [9:0] taps = `LFSR_TAPS;

    logic       feedback;

    // tap bit 6 has no place in this mapping
    always_comb
    begin
        feedback = randBits[0]
                 ^ (taps[9] & randBits[1]) ^ (taps[8] & randBits[2])
                 ^ (taps[7] & randBits[3]) ^ (taps[5] & randBits[4])
                 ^ (taps[4] & randBits[5]) ^ (taps[3] & randBits[6])
                 ^ (taps[2] & randBits[7]) ^ (taps[1] & randBits[8])
                 ^ (taps[0] & randBits[9]);
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            randBits <= `LFSR_SEED;
        else
            randBits <= {feedback, randBits[9:1]};  // shift right, new msb
    end

endmodule

`default_nettype wire

// File: tourEvaluator.sv
`default_nettype none

`include "ga_consts.svh"

module tourEvaluator import ga_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      coordWrEn,
    input  cityIdx_t  coordWrAddr,
    input  coord_t    coordWrX,
    input  coord_t    coordWrY,
    input  logic      evalStart,
    output routeIdx_t evalRoute,
    output cityIdx_t  evalPos,
    input  cityIdx_t  evalCity,
    output logic      distValid,
    output routeIdx_t distRoute,
    output dist_t     distValue,
    output logic      evalDone
);

    coord_t    coordX [`NUM_CITIES];
    coord_t    coordY [`NUM_CITIES];
    logic      active;
    logic [3:0] step;      // 0..NUM_CITIES+1 within one route
    routeIdx_t route;
    cityIdx_t  firstCity;
    cityIdx_t  prevCity;
    dist_t     sum;

    function automatic dist_t edgeLen(cityIdx_t a, cityIdx_t b);
        coord_t dx;
        coord_t dy;
        dx = (coordX[a] > coordX[b]) ? coordX[a] - coordX[b] : coordX[b] - coordX[a];
        dy = (coordY[a] > coordY[b]) ? coordY[a] - coordY[b] : coordY[b] - coordY[a];
        return dist_t'(dx) + dist_t'(dy);
    endfunction

    always_ff @(posedge CLK)
    begin
        if (coordWrEn)
        begin
            coordX[coordWrAddr] <= coordWrX;
            coordY[coordWrAddr] <= coordWrY;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            active <= 1'b0;
        else if (evalStart)
        begin
            active <= 1'b1;
            step   <= '0;
            route  <= '0;
        end
        else if (active)
        begin
            if (step == 4'(`NUM_CITIES + 1))
            begin
                step <= '0;
                if (route == routeIdx_t'(`POP_SIZE - 1))
                    active <= 1'b0;
                route <= route + 1'b1;
            end
            else
                step <= step + 1'b1;
        end
    end

    // read data trails the address by one step
    always_ff @(posedge CLK)
    begin
        if (step == 4'd1)
        begin
            firstCity <= evalCity;
            prevCity  <= evalCity;
            sum       <= '0;
        end
        else if (step >= 4'd2 && step <= 4'(`NUM_CITIES))
        begin
            sum      <= sum + edgeLen(prevCity, evalCity);
            prevCity <= evalCity;
        end
    end

    assign evalRoute = route;
    assign evalPos   = step[2:0];
    assign distValid = active && (step == 4'(`NUM_CITIES + 1));
    assign distRoute = route;
    assign distValue = sum + edgeLen(prevCity, firstCity);  // closing edge back to start
    assign evalDone  = distValid && (route == routeIdx_t'(`POP_SIZE - 1));

endmodule

`default_nettype wire

// File: popStore.sv
`default_nettype none

`include "ga_consts.svh"

module popStore import ga_pkg::*; (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             initPop,
    input  logic             bankSwap,
    input  routeIdx_t        evalRoute,
    input  cityIdx_t         evalPos,
    output cityIdx_t         evalCity,
    popWritePort.store       bld,
    input  cityIdx_t         bestRdPos,
    output cityIdx_t         bestRdCity
);

    cityIdx_t bank [2][`POP_SIZE][`NUM_CITIES];
    logic     bankSel;  // current (parent) bank

    always_ff @(posedge CLK)
    begin
        if (RESET)
            bankSel <= 1'b0;
        else if (bankSwap)
            bankSel <= !bankSel;
    end

    // identity tours in both banks, otherwise child writes
    always_ff @(posedge CLK)
    begin
        if (initPop)
        begin
            for (int b = 0; b < 2; b++)
                for (int r = 0; r < `POP_SIZE; r++)
                    for (int c = 0; c < `NUM_CITIES; c++)
                        bank[b][r][c] <= cityIdx_t'(c);
        end
        else if (bld.wrEn)
            bank[!bankSel][bld.wrRoute][bld.wrPos] <= bld.wrCity;
    end

    always_ff @(posedge CLK)
    begin
        evalCity   <= bank[bankSel][evalRoute][evalPos];
        bld.rdCity <= bank[bankSel][bld.rdRoute][bld.rdPos];
        bestRdCity <= bank[bankSel][0][bestRdPos];  // slot 0 holds the top elite
    end

endmodule

`default_nettype wire

// File: fitnessRanker.sv
`default_nettype none

`include "ga_consts.svh"

module fitnessRanker import ga_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      evalStart,
    input  logic      distValid,
    input  routeIdx_t distRoute,
    input  dist_t     distValue,
    input  routeIdx_t rankQuery,
    output routeIdx_t rankRoute,
    output dist_t     bestDistance,
    output logic      rankDone
);

    dist_t     rankDist [`POP_SIZE];
    routeIdx_t rankIdx  [`POP_SIZE];
    logic [$clog2(`POP_SIZE):0] count;         // entries held so far
    logic [`POP_SIZE-1:0]       displaced;     // entry moves down one slot

    // strictly longer entries move, equal ones keep their place
    always_comb
    begin
        for (int i = 0; i < `POP_SIZE; i++)
            displaced[i] = (count > i) && (rankDist[i] > distValue);
    end

    always_ff @(posedge CLK)
    begin
        if (distValid)
        begin
            if (displaced[0] || count == 0)
            begin
                rankDist[0] <= distValue;
                rankIdx[0]  <= distRoute;
            end
            for (int i = 1; i < `POP_SIZE; i++)
            begin
                if (displaced[i-1])
                begin
                    rankDist[i] <= rankDist[i-1];
                    rankIdx[i]  <= rankIdx[i-1];
                end
                else if (displaced[i] || count == i)
                begin
                    rankDist[i] <= distValue;
                    rankIdx[i]  <= distRoute;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            count        <= '0;
            rankDone     <= 1'b0;
            bestDistance <= '0;
        end
        else
        begin
            rankDone <= distValid && (count == `POP_SIZE - 1);
            if (evalStart)
                count <= '0;
            else if (distValid)
                count <= count + 1'b1;
            if (rankDone)
                bestDistance <= rankDist[0];  // held across the next evaluation
        end
    end

    assign rankRoute = rankIdx[rankQuery];

endmodule

`default_nettype wire

// File: offspringBuilder.sv
`default_nettype none

`include "ga_consts.svh"

module offspringBuilder import ga_pkg::*; (
    input  logic          CLK,
    input  logic          RESET,
    input  logic          buildStart,
    input  logic [9:0]    randBits,
    output routeIdx_t     rankQuery,
    input  routeIdx_t     rankRoute,
    popWritePort.builder  bld,
    output logic          buildDone
);

    logic       active;
    logic [3:0] step;       // 0..NUM_CITIES+1 per child slot
    routeIdx_t  slot;       // child slot being filled
    routeIdx_t  parentRoute;
    logic       mutate;
    cityIdx_t   posA;
    cityIdx_t   posB;
    routeIdx_t  candA;
    routeIdx_t  candB;
    logic [3:0] rdStep;
    logic [3:0] wrStep;
    cityIdx_t   wrIdx;

    // two random ranks, the better one wins
    assign candA = randBits[9:6];
    assign candB = randBits[8:5];

    always_comb
    begin
        if (slot < `ELITE_SIZE)
            rankQuery = slot;  // elites copy by rank
        else
            rankQuery = (candA < candB) ? candA : candB;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            active <= 1'b0;
        else if (buildStart)
        begin
            active <= 1'b1;
            step   <= '0;
            slot   <= '0;
        end
        else if (active)
        begin
            if (step == 4'(`NUM_CITIES + 1))
            begin
                step <= '0;
                if (slot == routeIdx_t'(`POP_SIZE - 1))
                    active <= 1'b0;
                slot <= slot + 1'b1;
            end
            else
                step <= step + 1'b1;
        end
    end

    // random fields are drawn on different cycles so they differ
    always_ff @(posedge CLK)
    begin
        if (active && step == 4'd0)
        begin
            parentRoute <= rankRoute;
            mutate      <= (slot >= `ELITE_SIZE) && (randBits[7:0] < `MUT_THRESHOLD);
        end
        if (active && step == 4'd1)
        begin
            posA <= randBits[9:7];
            posB <= randBits[2:0];
        end
    end

    assign rdStep = step - 4'd1;
    assign wrStep = step - 4'd2;
    assign wrIdx  = wrStep[2:0];

    // parent read in order, swap applied on the write address
    assign bld.rdRoute = parentRoute;
    assign bld.rdPos   = rdStep[2:0];
    assign bld.wrRoute = slot;
    assign bld.wrCity  = bld.rdCity;
    assign bld.wrEn    = active && (step >= 4'd2);
    assign bld.wrPos   = (mutate && wrIdx == posA) ? posB :
                         (mutate && wrIdx == posB) ? posA : wrIdx;

    assign buildDone = active && (step == 4'(`NUM_CITIES + 1))
                       && (slot == routeIdx_t'(`POP_SIZE - 1));

endmodule

`default_nettype wire

// File: gaController.sv
`default_nettype none

module gaController import ga_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      start,
    input  genCount_t numGenerations,
    input  logic      evalDone,
    input  logic      rankDone,
    input  logic      buildDone,
    output logic      initPop,
    output logic      evalStart,
    output logic      buildStart,
    output logic      bankSwap,
    output logic      genDone,
    output logic      busy,
    output logic      done
);

    gaState_t  state;
    genCount_t genCnt;    // generations finished in this run
    genCount_t genLimit;  // latched at start

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= IDLE;
            genCnt     <= '0;
            genLimit   <= '0;
            initPop    <= 1'b0;
            evalStart  <= 1'b0;
            buildStart <= 1'b0;
            bankSwap   <= 1'b0;
            genDone    <= 1'b0;
        end
        else
        begin
            // strobes last one cycle
            initPop    <= 1'b0;
            evalStart  <= 1'b0;
            buildStart <= 1'b0;
            bankSwap   <= 1'b0;
            genDone    <= 1'b0;

            unique case (state)
                IDLE, DONE:
                begin
                    if (start)
                    begin
                        state     <= EVAL;
                        genCnt    <= '0;
                        genLimit  <= numGenerations;
                        initPop   <= 1'b1;  // fresh identity population
                        evalStart <= 1'b1;
                    end
                end
                EVAL:
                begin
                    if (evalDone)
                        state <= RANK;
                end
                RANK:
                begin
                    if (rankDone)
                    begin
                        state      <= BUILD;
                        buildStart <= 1'b1;
                    end
                end
                BUILD:
                begin
                    if (buildDone)
                    begin
                        state    <= SWAP;
                        bankSwap <= 1'b1;
                        genDone  <= 1'b1;
                        genCnt   <= genCnt + 1'b1;
                    end
                end
                SWAP:
                begin
                    if (genCnt == genLimit)
                        state <= DONE;
                    else
                    begin
                        state     <= EVAL;
                        evalStart <= 1'b1;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign busy = (state != IDLE) && (state != DONE);
    assign done = (state == DONE);

endmodule

`default_nettype wire

// File: gaTspTop.sv
`default_nettype none

module gaTspTop import ga_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      coordWrEn,
    input  cityIdx_t  coordWrAddr,
    input  coord_t    coordWrX,
    input  coord_t    coordWrY,
    input  logic      start,
    input  genCount_t numGenerations,
    input  cityIdx_t  bestRdPos,
    output logic      busy,
    output logic      genDone,
    output dist_t     bestDistance,
    output logic      done,
    output cityIdx_t  bestRdCity
);

    logic [9:0] randBits;
    logic       initPop;
    logic       evalStart;
    logic       buildStart;
    logic       bankSwap;
    logic       evalDone;
    logic       rankDone;
    logic       buildDone;
    routeIdx_t  evalRoute;
    cityIdx_t   evalPos;
    cityIdx_t   evalCity;
    logic       distValid;
    routeIdx_t  distRoute;
    dist_t      distValue;
    routeIdx_t  rankQuery;
    routeIdx_t  rankRoute;

    popWritePort bldBus ();

    gaLfsr lfsr (
        .CLK      (CLK),
        .RESET    (RESET),
        .randBits (randBits)
    );

    tourEvaluator evaluator (
        .CLK         (CLK),
        .RESET       (RESET),
        .coordWrEn   (coordWrEn),
        .coordWrAddr (coordWrAddr),
        .coordWrX    (coordWrX),
        .coordWrY    (coordWrY),
        .evalStart   (evalStart),
        .evalRoute   (evalRoute),
        .evalPos     (evalPos),
        .evalCity    (evalCity),
        .distValid   (distValid),
        .distRoute   (distRoute),
        .distValue   (distValue),
        .evalDone    (evalDone)
    );

    popStore store (
        .CLK        (CLK),
        .RESET      (RESET),
        .initPop    (initPop),
        .bankSwap   (bankSwap),
        .evalRoute  (evalRoute),
        .evalPos    (evalPos),
        .evalCity   (evalCity),
        .bld        (bldBus.store),
        .bestRdPos  (bestRdPos),
        .bestRdCity (bestRdCity)
    );

    fitnessRanker ranker (
        .CLK          (CLK),
        .RESET        (RESET),
        .evalStart    (evalStart),
        .distValid    (distValid),
        .distRoute    (distRoute),
        .distValue    (distValue),
        .rankQuery    (rankQuery),
        .rankRoute    (rankRoute),
        .bestDistance (bestDistance),
        .rankDone     (rankDone)
    );

    offspringBuilder builder (
        .CLK        (CLK),
        .RESET      (RESET),
        .buildStart (buildStart),
        .randBits   (randBits),
        .rankQuery  (rankQuery),
        .rankRoute  (rankRoute),
        .bld        (bldBus.builder),
        .buildDone  (buildDone)
    );

    gaController controller (
        .CLK            (CLK),
        .RESET          (RESET),
        .start          (start),
        .numGenerations (numGenerations),
        .evalDone       (evalDone),
        .rankDone       (rankDone),
        .buildDone      (buildDone),
        .initPop        (initPop),
        .evalStart      (evalStart),
        .buildStart     (buildStart),
        .bankSwap       (bankSwap),
        .genDone        (genDone),
        .busy           (busy),
        .done           (done)
    );

endmodule

`default_nettype wire

// File: tb_gaTsp_props.sv
`default_nettype none

module gaTspProps (
    input logic CLK,
    input logic RESET,
    input logic genDone,
    input logic busy,
    input logic done,
    input logic coordWrEn
);

    timeunit 1ns;
    timeprecision 100ps;

    genDoneSingle: assert property (@(posedge CLK) disable iff (RESET) genDone |=> !genDone)
        else $error("genDone stayed high for more than one cycle");

    // a run only ends by handing over from busy to done
    busyFallsIntoDone: assert property (@(posedge CLK) disable iff (RESET) $fell(busy) |-> done)
        else $error("busy fell without done rising");

    // map must not change under a running evaluation
    coordIdleOnly: assert property (@(posedge CLK) disable iff (RESET) $rose(coordWrEn) |-> !busy)
        else $error("coordinate write started while busy");

endmodule

bind gaTspTop gaTspProps props_i (
    .CLK       (CLK),
    .RESET     (RESET),
    .genDone   (genDone),
    .busy      (busy),
    .done      (done),
    .coordWrEn (coordWrEn)
);

`default_nettype wire

// File: tb_gaTsp.sv
`default_nettype none

`include "ga_consts.svh"

module tb_gaTsp import ga_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned LCG_SEED = 39472;
    // 2 runs, at most 12 generations each, well under 600 cycles per generation
    localparam int TIMEOUT_CYCLES = 2 * 12 * 600;

    logic      CLK;
    logic      RESET;
    logic      coordWrEn;
    cityIdx_t  coordWrAddr;
    coord_t    coordWrX;
    coord_t    coordWrY;
    logic      start;
    genCount_t numGenerations;
    cityIdx_t  bestRdPos;
    logic      busy;
    logic      genDone;
    dist_t     bestDistance;
    logic      done;
    cityIdx_t  bestRdCity;

    coord_t      cityX [`NUM_CITIES];  // testbench copy of the map
    coord_t      cityY [`NUM_CITIES];
    int unsigned lcgState;
    int          cycleCount = 0;

    // state of the comparing process
    int   expFirstBest = 0;  // identity tour length of the current map
    int   genSeen = 0;
    int   runCount = 0;
    int   lastBest = 0;
    logic wasBusy = 1'b0;
    logic wasDone = 1'b0;
    logic wasGenDone = 1'b0;

    gaTspTop dut_i (
        .CLK            (CLK),
        .RESET          (RESET),
        .coordWrEn      (coordWrEn),
        .coordWrAddr    (coordWrAddr),
        .coordWrX       (coordWrX),
        .coordWrY       (coordWrY),
        .start          (start),
        .numGenerations (numGenerations),
        .bestRdPos      (bestRdPos),
        .busy           (busy),
        .genDone        (genDone),
        .bestDistance   (bestDistance),
        .done           (done),
        .bestRdCity     (bestRdCity)
    );

    always #4 CLK = ~CLK;

    function automatic int unsigned lcgNext(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int absDiff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // closed tour, last city links back to the first
    function automatic int tourLength(input cityIdx_t tour [`NUM_CITIES]);
        int total;
        int a;
        int b;
        total = 0;
        for (int i = 0; i < `NUM_CITIES; i++)
        begin
            a = tour[i];
            b = tour[(i + 1) % `NUM_CITIES];
            total += absDiff(cityX[a], cityX[b]) + absDiff(cityY[a], cityY[b]);
        end
        return total;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic loadCoords();
        for (int c = 0; c < `NUM_CITIES; c++)
        begin
            lcgState = lcgNext(lcgState);
            cityX[c] = coord_t'(lcgState >> 16);  // upper bits are the better ones
            lcgState = lcgNext(lcgState);
            cityY[c] = coord_t'(lcgState >> 16);
            coordWrEn   = 1'b1;
            coordWrAddr = cityIdx_t'(c);
            coordWrX    = cityX[c];
            coordWrY    = cityY[c];
            @(negedge CLK);
        end
        coordWrEn = 1'b0;
    endtask

    task automatic runOnce(input int gens, input logic pokeStart);
        cityIdx_t               identity [`NUM_CITIES];
        cityIdx_t               bestTour [`NUM_CITIES];
        logic [`NUM_CITIES-1:0] seenCity;
        int                     len;
        loadCoords();
        for (int i = 0; i < `NUM_CITIES; i++)
            identity[i] = cityIdx_t'(i);
        expFirstBest   = tourLength(identity);
        numGenerations = genCount_t'(gens);
        start          = 1'b1;
        @(negedge CLK);
        start = 1'b0;
        assert (busy) else failRun("busy did not rise on the cycle after start");

        if (pokeStart)
        begin
            // a start in the middle of a run must be ignored
            while (!genDone)
                @(negedge CLK);
            repeat (3) @(negedge CLK);
            start = 1'b1;
            @(negedge CLK);
            start = 1'b0;
        end

        while (!done)
            @(negedge CLK);

        bestRdPos = '0;
        for (int p = 0; p < `NUM_CITIES; p++)
        begin
            @(negedge CLK);
            bestTour[p] = bestRdCity;      // one cycle behind bestRdPos
            bestRdPos   = cityIdx_t'(p + 1);
        end

        seenCity = '0;
        for (int p = 0; p < `NUM_CITIES; p++)
        begin
            assert (!seenCity[bestTour[p]])
            else failRun($sformatf("best route visits city %0d twice", bestTour[p]));
            seenCity[bestTour[p]] = 1'b1;
        end
        len = tourLength(bestTour);
        assert (len == int'(bestDistance))
        else failRun($sformatf("Mismatch at %0t ns: bestDistance %0d, tour of bestRdCity %0d",
                               $time, bestDistance, len));
    endtask

    initial
    begin
        CLK            = 1'b0;
        RESET          = 1'b1;
        coordWrEn      = 1'b0;
        coordWrAddr    = '0;
        coordWrX       = '0;
        coordWrY       = '0;
        start          = 1'b0;
        numGenerations = '0;
        bestRdPos      = '0;
        lcgState       = LCG_SEED;
        repeat (16) @(negedge CLK);
        RESET = 1'b0;
        repeat (20) @(negedge CLK);  // quiet window before the first start

        runOnce(10, 1'b1);
        runOnce(6, 1'b0);   // new map, fewer generations

        $display("All checks passed");
        $finish;
    end

    always @(posedge CLK)
    begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES)
            failRun($sformatf("Timeout after %0d cycles without finishing", TIMEOUT_CYCLES));
    end

    // outputs are sampled mid-cycle, half a period after they change
    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            if (busy && !wasBusy)
            begin
                runCount++;
                genSeen = 0;
            end
            if (runCount == 0)
                assert (!busy && !done && !genDone)
                else failRun("busy, done or genDone went high before the first start");

            if (genDone)
            begin
                genSeen++;
                assert (genSeen <= int'(numGenerations))
                else failRun("more genDone pulses than generations requested");
                if (genSeen == 1)
                    assert (int'(bestDistance) == expFirstBest)
                    else failRun($sformatf("Mismatch at %0t ns: bestDistance %0d, expected %0d",
                                           $time, bestDistance, expFirstBest));
                else
                    assert (int'(bestDistance) <= lastBest)
                    else failRun($sformatf("Mismatch at %0t ns: bestDistance %0d, above previous %0d",
                                           $time, bestDistance, lastBest));
                lastBest = bestDistance;
            end

            if (wasGenDone)
            begin
                if (genSeen == int'(numGenerations))
                    assert (done && !busy)
                    else failRun("done did not rise with busy falling after the last genDone");
                else
                    assert (busy && !done)
                    else failRun("run stopped before all generations were finished");
            end

            if (done && !wasDone)
                assert (genSeen == int'(numGenerations))
                else failRun($sformatf("Mismatch at %0t ns: genDone count %0d, expected %0d",
                                       $time, genSeen, numGenerations));
            if (wasDone && !done)
                assert (busy) else failRun("done fell without a new start");

            wasBusy    = busy;
            wasDone    = done;
            wasGenDone = genDone;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
ga_pkg.sv
ga_if.sv
gaLfsr.sv
tourEvaluator.sv
popStore.sv
fitnessRanker.sv
offspringBuilder.sv
gaController.sv
gaTspTop.sv
tb_gaTsp_props.sv
tb_gaTsp.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal -f flist.f \
    --top-module tb_gaTsp -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0
